// ==== common/cpuPkg.sv ====
`default_nettype none

package cpuPkg;

    localparam int regCount = 16;

    typedef logic [15:0] word_t;
    typedef logic [3:0] regAddr_t;

    typedef enum logic [3:0] {
        opAdd  = 4'd0,
        opSub  = 4'd1,
        opAnd  = 4'd2,
        opOr   = 4'd3,
        opXor  = 4'd4,
        opAddi = 4'd5,
        opLdi  = 4'd6,
        opLd   = 4'd7,
        opSt   = 4'd8,
        opHalt = 4'd9
    } opcode_t;

    // One access per strobe, answered by a single done pulse
    typedef struct packed {
        logic  strobe;
        logic  write;
        word_t addr;
        word_t wdata;
    } memReq_t;

    typedef struct packed {
        logic  done;
        word_t rdata;
    } memRsp_t;

    // Fourth field is an unsigned offset for ADDI, LD and ST
    typedef struct packed {
        opcode_t  op;
        regAddr_t rd;
        regAddr_t ra;
        regAddr_t rb;
    } regForm_t;

    // LDI only
    typedef struct packed {
        opcode_t    op;
        regAddr_t   rd;
        logic [7:0] imm8;
    } immForm_t;

    typedef union packed {
        regForm_t regForm;
        immForm_t immForm;
    } instr_t;

    typedef struct packed {
        logic     isStore;
        regAddr_t dest;
        word_t    addr;
        word_t    storeData;
    } lsuCmd_t;

endpackage

`default_nettype wire

// ==== core/fetchUnit.sv ====
`default_nettype none

module fetchUnit import cpuPkg::*; #(
    parameter word_t resetPc = '0
) (
    input  logic   clk,
    input  logic   arstN,

    output logic   fetchReq,
    output word_t  fetchAddr,
    input  logic   fetchDone,
    input  word_t  fetchData,

    input  logic   instrTaken,
    output logic   instrValid,
    output instr_t instr
);

    word_t  pc;
    instr_t instrBuf;

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            pc         <= resetPc;
            instrValid <= 1'b0;
        end else begin
            if (fetchDone) begin
                instrValid <= 1'b1;
            end else if (instrTaken) begin
                instrValid <= 1'b0;
                pc         <= pc + word_t'(1);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (fetchDone) begin
            instrBuf <= instr_t'(fetchData);
        end
    end

    // Request stays up for the whole access, arbiter tracks the outstanding one
    assign fetchReq  = !instrValid;
    assign fetchAddr = pc;
    assign instr     = instrBuf;

    bufFullNoFetch: assert property (@(posedge clk) disable iff (!arstN)
        fetchDone |-> !instrValid)
        else $error("fetch data returned while the instruction buffer is full");

endmodule

`default_nettype wire

// ==== core/issueStage.sv ====
`default_nettype none

module issueStage import cpuPkg::*; (
    input  logic     clk,
    input  logic     arstN,

    input  logic     instrValid,
    input  instr_t   instr,
    output logic     instrTaken,

    output regAddr_t readAAddr,
    output regAddr_t readBAddr,
    output logic     readAEn,
    output logic     readBEn,
    input  word_t    readAData,
    input  word_t    readBData,
    input  logic     stall,

    output regAddr_t aluWrAddr,
    output logic     aluWrEn,
    output word_t    aluWrData,

    output logic     tagRequest,
    output regAddr_t tagAddr,
    input  logic     destDirty,

    output logic     lsuStart,
    output lsuCmd_t  lsuCmd,
    input  logic     lsuBusy,
    input  logic     regsSync,

    output logic     halted
);

    opcode_t  op;
    regAddr_t rd;
    word_t    offsetSum;
    word_t    aluResult;
    logic     usesA;
    logic     usesB;
    logic     writesRd;
    logic     isLoad;
    logic     isStore;
    logic     isHalt;
    logic     canIssue;
    logic     haltNow;
    logic     haltedQ;

    assign op = instr.regForm.op;
    assign rd = instr.regForm.rd;

    // ra plus the unsigned 4-bit offset, shared by ADDI and the memory ops
    assign offsetSum = readAData + word_t'(instr.regForm.rb);

    always_comb begin
        usesA     = 1'b0;
        usesB     = 1'b0;
        writesRd  = 1'b0;
        isLoad    = 1'b0;
        isStore   = 1'b0;
        isHalt    = 1'b0;
        aluResult = '0;
        case (op)
            opAdd, opSub, opAnd, opOr, opXor: begin
                usesA    = 1'b1;
                usesB    = 1'b1;
                writesRd = 1'b1;
                case (op)
                    opAdd:   aluResult = readAData + readBData;
                    opSub:   aluResult = readAData - readBData;
                    opAnd:   aluResult = readAData & readBData;
                    opOr:    aluResult = readAData | readBData;
                    default: aluResult = readAData ^ readBData;
                endcase
            end
            opAddi: begin
                usesA     = 1'b1;
                writesRd  = 1'b1;
                aluResult = offsetSum;
            end
            opLdi: begin
                writesRd  = 1'b1;
                aluResult = word_t'(instr.immForm.imm8);
            end
            opLd: begin
                usesA    = 1'b1;
                writesRd = 1'b1;
                isLoad   = 1'b1;
            end
            opSt: begin
                usesA   = 1'b1;
                usesB   = 1'b1;
                isStore = 1'b1;
            end
            opHalt: isHalt = 1'b1;
            // Unused encodings retire as no-ops
            default: ;
        endcase
    end

    // Store data comes from rd through port B
    assign readAAddr = instr.regForm.ra;
    assign readBAddr = isStore ? rd : instr.regForm.rb;
    assign readAEn   = instrValid && usesA;
    assign readBEn   = instrValid && usesB;

    assign canIssue = instrValid && !isHalt && !stall
                   && !(writesRd && destDirty)
                   && !((isLoad || isStore) && lsuBusy);

    assign instrTaken = canIssue;

    assign aluWrEn   = canIssue && writesRd && !isLoad;
    assign aluWrAddr = rd;
    assign aluWrData = aluResult;

    assign tagRequest = canIssue && isLoad;
    assign tagAddr    = rd;

    assign lsuStart          = canIssue && (isLoad || isStore);
    assign lsuCmd.isStore    = isStore;
    assign lsuCmd.dest       = rd;
    assign lsuCmd.addr       = offsetSum;
    assign lsuCmd.storeData  = readBData;

    // Nothing in flight once the LSU is idle and all dirty bits are clear
    assign haltNow = instrValid && isHalt && !lsuBusy && regsSync;

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            haltedQ <= 1'b0;
        end else if (haltNow) begin
            haltedQ <= 1'b1;
        end
    end

    assign halted = haltedQ || haltNow;

endmodule

`default_nettype wire

// ==== core/loadStoreUnit.sv ====
`default_nettype none

module loadStoreUnit import cpuPkg::*; (
    input  logic     clk,
    input  logic     arstN,

    input  logic     lsuStart,
    input  lsuCmd_t  lsuCmd,
    output logic     lsuBusy,

    output logic     lsuReq,
    output logic     lsuWrite,
    output word_t    lsuAddr,
    output word_t    lsuWdata,
    input  logic     lsuDone,
    input  word_t    lsuRdata,

    output regAddr_t memWrAddr,
    output logic     memWrEn,
    output word_t    memWrData
);

    lsuCmd_t cmdQ;
    logic    busyQ;

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            busyQ <= 1'b0;
        end else if (lsuStart) begin
            busyQ <= 1'b1;
        end else if (lsuDone) begin
            busyQ <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (lsuStart) begin
            cmdQ <= lsuCmd;
        end
    end

    assign lsuBusy  = busyQ;
    assign lsuReq   = busyQ;
    assign lsuWrite = cmdQ.isStore;
    assign lsuAddr  = cmdQ.addr;
    assign lsuWdata = cmdQ.storeData;

    // Load data goes straight into the register file on the done cycle
    assign memWrEn   = busyQ && lsuDone && !cmdQ.isStore;
    assign memWrAddr = cmdQ.dest;
    assign memWrData = lsuRdata;

    startWhenIdle: assert property (@(posedge clk) disable iff (!arstN)
        lsuStart |-> !lsuBusy)
        else $error("load/store issued while the LSU is busy");

endmodule

`default_nettype wire

// ==== core/registerFile.sv ====
`default_nettype none

module registerFile import cpuPkg::*; (
    input  logic     clk,
    input  logic     arstN,

    input  regAddr_t readAAddr,
    input  regAddr_t readBAddr,
    input  logic     readAEn,
    input  logic     readBEn,
    output word_t    readAData,
    output word_t    readBData,

    input  regAddr_t aluWrAddr,
    input  logic     aluWrEn,
    input  word_t    aluWrData,

    input  regAddr_t memWrAddr,
    input  logic     memWrEn,
    input  word_t    memWrData,

    input  logic     tagRequest,
    input  regAddr_t tagAddr,
    input  regAddr_t tagProbe,

    output logic     stall,
    output logic     destDirty,
    output logic     regsSync
);

    // r0 has no storage
    word_t                regs [1:regCount-1];
    logic  [regCount-1:0] dirty;

    always_ff @(posedge clk) begin
        if (aluWrEn && aluWrAddr != '0) begin
            regs[aluWrAddr] <= aluWrData;
        end
        if (memWrEn && memWrAddr != '0) begin
            regs[memWrAddr] <= memWrData;
        end
    end

    // Set at load issue, cleared when the load data lands
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            dirty <= '0;
        end else begin
            if (memWrEn) begin
                dirty[memWrAddr] <= 1'b0;
            end
            if (tagRequest && tagAddr != '0) begin
                dirty[tagAddr] <= 1'b1;
            end
        end
    end

    assign readAData = (readAEn && readAAddr != '0) ? regs[readAAddr] : '0;
    assign readBData = (readBEn && readBAddr != '0) ? regs[readBAddr] : '0;

    assign stall     = (readAEn && dirty[readAAddr]) || (readBEn && dirty[readBAddr]);
    assign destDirty = dirty[tagProbe];
    assign regsSync  = ~|dirty;

    memWrOnlyDirty: assert property (@(posedge clk) disable iff (!arstN)
        memWrEn && memWrAddr != '0 |-> dirty[memWrAddr])
        else $error("load data written to clean register r%0d", memWrAddr);

    aluWrNeverDirty: assert property (@(posedge clk) disable iff (!arstN)
        aluWrEn && aluWrAddr != '0 |-> !dirty[aluWrAddr])
        else $error("ALU write to register r%0d with a load pending", aluWrAddr);

endmodule

`default_nettype wire

// ==== rtl/cpuTop.sv ====
`default_nettype none

module cpuTop import cpuPkg::*; #(
    parameter word_t resetPc = '0
) (
    input  logic    clk,
    input  logic    arstN,
    output memReq_t memReq,
    input  memRsp_t memRsp,
    output logic    halted
);

    logic     fetchReq;
    word_t    fetchAddr;
    logic     fetchDone;
    word_t    fetchData;
    logic     instrTaken;
    logic     instrValid;
    instr_t   instr;

    regAddr_t readAAddr;
    regAddr_t readBAddr;
    logic     readAEn;
    logic     readBEn;
    word_t    readAData;
    word_t    readBData;
    logic     stall;
    regAddr_t aluWrAddr;
    logic     aluWrEn;
    word_t    aluWrData;
    logic     tagRequest;
    regAddr_t tagAddr;
    logic     destDirty;
    logic     regsSync;

    logic     lsuStart;
    lsuCmd_t  lsuCmd;
    logic     lsuBusy;
    logic     lsuReq;
    logic     lsuWrite;
    word_t    lsuAddr;
    word_t    lsuWdata;
    logic     lsuDone;
    word_t    lsuRdata;
    regAddr_t memWrAddr;
    logic     memWrEn;
    word_t    memWrData;

    fetchUnit #(.resetPc(resetPc)) u_fetchUnit (.*);

    issueStage u_issueStage (.*);

    // Write-after-write check looks at the buffered instruction's destination
    registerFile u_registerFile (
        .tagProbe (instr.regForm.rd),
        .*
    );

    loadStoreUnit u_loadStoreUnit (.*);

    memArbiter u_memArbiter (.*);

endmodule

`default_nettype wire

// ==== rtl/memArbiter.sv ====
`default_nettype none

module memArbiter import cpuPkg::*; (
    input  logic    clk,
    input  logic    arstN,

    input  logic    fetchReq,
    input  word_t   fetchAddr,
    output logic    fetchDone,
    output word_t   fetchData,

    input  logic    lsuReq,
    input  logic    lsuWrite,
    input  word_t   lsuAddr,
    input  word_t   lsuWdata,
    output logic    lsuDone,
    output word_t   lsuRdata,

    output memReq_t memReq,
    input  memRsp_t memRsp
);

    logic  busy;
    logic  lsuOwns;
    logic  strobeQ;
    logic  grant;
    logic  writeQ;
    word_t addrQ;
    word_t wdataQ;

    assign grant = !busy && (lsuReq || fetchReq);

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            busy    <= 1'b0;
            lsuOwns <= 1'b0;
            strobeQ <= 1'b0;
        end else begin
            strobeQ <= grant;
            if (grant) begin
                busy    <= 1'b1;
                lsuOwns <= lsuReq;
            end else if (memRsp.done) begin
                busy <= 1'b0;
            end
        end
    end

    // LSU wins a tie with fetch
    always_ff @(posedge clk) begin
        if (grant) begin
            writeQ <= lsuReq && lsuWrite;
            addrQ  <= lsuReq ? lsuAddr : fetchAddr;
            wdataQ <= lsuWdata;
        end
    end

    assign memReq.strobe = strobeQ;
    assign memReq.write  = writeQ;
    assign memReq.addr   = addrQ;
    assign memReq.wdata  = wdataQ;

    assign fetchDone = memRsp.done && busy && !lsuOwns;
    assign lsuDone   = memRsp.done && busy && lsuOwns;
    assign fetchData = memRsp.rdata;
    assign lsuRdata  = memRsp.rdata;

    doneWhileBusy: assert property (@(posedge clk) disable iff (!arstN)
        memRsp.done |-> busy)
        else $error("memory done with no access outstanding");

    oneOutstanding: assert property (@(posedge clk) disable iff (!arstN)
        memReq.strobe |=> (!memReq.strobe until memRsp.done))
        else $error("bus strobed again before the previous access finished");

endmodule

`default_nettype wire

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 -f sources.f --top-module cpuTb -o cpuSim

output=$(./obj_dir/cpuSim) || true
printf '%s\n' "$output"

if printf '%s\n' "$output" | grep -qx "Test passed"; then
    exit 0
fi
exit 1

// ==== sources.f ====
common/cpuPkg.sv
core/fetchUnit.sv
core/issueStage.sv
core/registerFile.sv
core/loadStoreUnit.sv
rtl/memArbiter.sv
rtl/cpuTop.sv
testbench/cpuTb.sv

// ==== testbench/cpuTb.sv ====
`default_nettype none

module cpuTb import cpuPkg::*; ();

    timeunit 1ns;
    timeprecision 1ps;

    logic    clk = 1'b0;
    logic    arstN;
    memReq_t memReq;
    memRsp_t memRsp;
    logic    halted;

    word_t       mem    [0:255];
    word_t       refMem [0:255];
    word_t       prog   [$];
    memReq_t     expStores [$];
    memReq_t     expStore;
    logic        memBusy;
    logic [31:0] lfsrState = 32'h36d7;
    int          errorCount;
    int          testsRun;
    int          testsFailed;
    int          cycleCount;
    int          cycleLimit;

    cpuTop u_dut (
        .clk    (clk),
        .arstN  (arstN),
        .memReq (memReq),
        .memRsp (memRsp),
        .halted (halted)
    );

    always #5 clk = ~clk;

    function automatic logic [31:0] galoisStep(input logic [31:0] state);
        logic [31:0] next;
        next = state >> 1;
        if (state[0]) begin
            next = next ^ 32'h80200003;
        end
        return next;
    endfunction

    // Two bits per access give 1 to 4 cycles
    function automatic int drawLatency();
        int value;
        int b;
        value = 0;
        for (b = 0; b < 2; b++) begin
            value = (value << 1) | int'(lfsrState[0]);
            lfsrState = galoisStep(lfsrState);
        end
        return value + 1;
    endfunction

    function automatic word_t encodeReg(input opcode_t op, input int rd, input int ra,
                                        input int rb);
        instr_t w;
        w.regForm.op = op;
        w.regForm.rd = regAddr_t'(rd);
        w.regForm.ra = regAddr_t'(ra);
        w.regForm.rb = regAddr_t'(rb);
        return w;
    endfunction

    function automatic word_t encodeImm(input opcode_t op, input int rd, input int imm);
        instr_t w;
        w.immForm.op   = op;
        w.immForm.rd   = regAddr_t'(rd);
        w.immForm.imm8 = 8'(imm);
        return w;
    endfunction

    // ISA model over refMem; fills expStores and returns the instruction count
    function automatic int runReference();
        word_t   regs [0:15];
        instr_t  ins;
        word_t   pc;
        word_t   addr;
        memReq_t st;
        int      count;
        int      i;
        for (i = 0; i < 16; i++) begin
            regs[i] = '0;
        end
        pc = '0;
        count = 0;
        while (count < 256) begin
            ins = refMem[pc[7:0]];
            pc = pc + word_t'(1);
            count++;
            addr = regs[ins.regForm.ra] + word_t'(ins.regForm.rb);
            case (ins.regForm.op)
                opAdd:  regs[ins.regForm.rd] = regs[ins.regForm.ra] + regs[ins.regForm.rb];
                opSub:  regs[ins.regForm.rd] = regs[ins.regForm.ra] - regs[ins.regForm.rb];
                opAnd:  regs[ins.regForm.rd] = regs[ins.regForm.ra] & regs[ins.regForm.rb];
                opOr:   regs[ins.regForm.rd] = regs[ins.regForm.ra] | regs[ins.regForm.rb];
                opXor:  regs[ins.regForm.rd] = regs[ins.regForm.ra] ^ regs[ins.regForm.rb];
                opAddi: regs[ins.regForm.rd] = addr;
                opLdi:  regs[ins.immForm.rd] = word_t'(ins.immForm.imm8);
                opLd:   regs[ins.regForm.rd] = refMem[addr[7:0]];
                opSt: begin
                    st.strobe = 1'b1;
                    st.write  = 1'b1;
                    st.addr   = addr;
                    st.wdata  = regs[ins.regForm.rd];
                    refMem[addr[7:0]] = st.wdata;
                    expStores.push_back(st);
                end
                opHalt: return count;
                default: ;
            endcase
            regs[0] = '0;
        end
        return count;
    endfunction

    task automatic checkMemReq(input memReq_t got, input memReq_t exp);
        if (got !== exp) begin
            $display("CHECK FAILED at %0t: memReq got addr=%h wdata=%h expected addr=%h wdata=%h",
                     $time, got.addr, got.wdata, exp.addr, exp.wdata);
            errorCount++;
        end
    endtask

    task automatic checkHalt(input logic got, input logic exp);
        if (got !== exp) begin
            $display("CHECK FAILED at %0t: halted got %b expected %b", $time, got, exp);
            errorCount++;
        end
    endtask

    // Memory with one outstanding access, answered 1 to 4 cycles after the strobe
    initial begin : memoryModel
        memReq_t req;
        int      latency;
        memRsp  = '0;
        memBusy = 1'b0;
        forever begin
            @(negedge clk);
            if (arstN && memReq.strobe) begin
                req = memReq;
                memBusy = 1'b1;
                latency = drawLatency();
                repeat (latency) @(posedge clk);
                #1;
                if (req.write) begin
                    mem[req.addr[7:0]] = req.wdata;
                    memRsp.rdata = '0;
                end else begin
                    memRsp.rdata = mem[req.addr[7:0]];
                end
                memRsp.done = 1'b1;
                @(posedge clk);
                #1;
                memRsp.done = 1'b0;
                memBusy = 1'b0;
            end
        end
    end

    // Stores seen on the bus, in order
    always @(negedge clk) begin
        if (arstN && memReq.strobe && memReq.write) begin
            if (halted) begin
                $display("Store to %h seen after halted was raised", memReq.addr);
                errorCount++;
            end
            if (expStores.size() == 0) begin
                $display("Unexpected extra store to %h with data %h", memReq.addr, memReq.wdata);
                errorCount++;
            end else begin
                expStore = expStores.pop_front();
                checkMemReq(memReq, expStore);
            end
        end
    end

    always @(posedge clk) begin
        cycleCount++;
        if (cycleCount > cycleLimit) begin
            $display("Timeout: run exceeded its limit of %0d cycles", cycleLimit);
            $display("Test failed");
            $finish;
        end
    end

    task automatic runTest(input string name);
        int count;
        int errorsBefore;
        int i;
        errorsBefore = errorCount;
        for (i = 0; i < 256; i++) begin
            mem[i] = word_t'(i * 257) ^ 16'ha5c3;
        end
        for (i = 0; i < prog.size(); i++) begin
            mem[i] = prog[i];
        end
        for (i = 0; i < 256; i++) begin
            refMem[i] = mem[i];
        end
        expStores.delete();
        count = runReference();
        cycleLimit = cycleLimit + 20 * count + 10;
        @(posedge clk);
        #1 arstN = 1'b0;
        repeat (5) @(posedge clk);
        #1 arstN = 1'b1;
        do @(negedge clk); while (!halted);
        if (expStores.size() != 0) begin
            $display("%0d expected store(s) missing when halted rose", expStores.size());
            errorCount++;
        end
        if (memBusy) begin
            $display("halted rose with a memory access still outstanding");
            errorCount++;
        end
        repeat (20) begin
            @(negedge clk);
            checkHalt(halted, 1'b1);
        end
        testsRun++;
        if (errorCount == errorsBefore) begin
            $display("PASS %s (%0d instructions)", name, count);
        end else begin
            testsFailed++;
            $display("FAIL %s (%0d errors)", name, errorCount - errorsBefore);
        end
    endtask

    initial begin
        arstN       = 1'b0;
        errorCount  = 0;
        testsRun    = 0;
        testsFailed = 0;
        cycleCount  = 0;
        cycleLimit  = 0;

        // SUB wraps since 0x35 < 0xc7
        prog.delete();
        prog.push_back(encodeImm(opLdi, 1, 8'h35));
        prog.push_back(encodeImm(opLdi, 2, 8'hc7));
        prog.push_back(encodeReg(opAdd, 3, 1, 2));
        prog.push_back(encodeReg(opSub, 4, 1, 2));
        prog.push_back(encodeReg(opAnd, 5, 1, 2));
        prog.push_back(encodeReg(opOr, 6, 1, 2));
        prog.push_back(encodeReg(opXor, 7, 1, 2));
        prog.push_back(encodeReg(opAddi, 8, 2, 15));
        prog.push_back(encodeImm(opLdi, 9, 8'h80));
        for (int k = 0; k < 6; k++) begin
            prog.push_back(encodeReg(opSt, 3 + k, 9, k));
        end
        prog.push_back(encodeReg(opHalt, 0, 0, 0));
        runTest("aluOps");

        prog.delete();
        prog.push_back(encodeImm(opLdi, 9, 8'h80));
        prog.push_back(encodeReg(opLd, 1, 9, 3));
        prog.push_back(encodeReg(opAdd, 2, 1, 1));
        prog.push_back(encodeReg(opLd, 3, 9, 4));
        prog.push_back(encodeReg(opAdd, 4, 3, 1));
        prog.push_back(encodeReg(opSub, 5, 4, 3));
        prog.push_back(encodeReg(opSt, 2, 9, 10));
        prog.push_back(encodeReg(opSt, 4, 9, 11));
        prog.push_back(encodeReg(opSt, 5, 9, 12));
        prog.push_back(encodeReg(opHalt, 0, 0, 0));
        runTest("loadUse");

        prog.delete();
        prog.push_back(encodeImm(opLdi, 0, 8'h5a));
        prog.push_back(encodeImm(opLdi, 9, 8'h80));
        prog.push_back(encodeReg(opSt, 0, 9, 0));
        prog.push_back(encodeReg(opAddi, 2, 0, 7));
        prog.push_back(encodeReg(opSt, 2, 9, 1));
        prog.push_back(encodeReg(opHalt, 0, 0, 0));
        runTest("zeroRegister");

        prog.delete();
        prog.push_back(encodeImm(opLdi, 9, 8'h80));
        prog.push_back(encodeReg(opLd, 3, 9, 2));
        prog.push_back(encodeImm(opLdi, 3, 8'h77));
        prog.push_back(encodeReg(opSt, 3, 9, 6));
        prog.push_back(encodeReg(opHalt, 0, 0, 0));
        runTest("writeAfterWrite");

        prog.delete();
        prog.push_back(encodeImm(opLdi, 9, 8'h90));
        prog.push_back(encodeImm(opLdi, 1, 8'h11));
        prog.push_back(encodeReg(opSt, 1, 9, 0));
        prog.push_back(encodeReg(opLd, 2, 9, 0));
        prog.push_back(encodeReg(opAddi, 3, 2, 1));
        prog.push_back(encodeReg(opSt, 3, 9, 0));
        prog.push_back(encodeReg(opLd, 4, 9, 0));
        prog.push_back(encodeReg(opSt, 4, 9, 1));
        prog.push_back(encodeImm(opLdi, 5, 8'h22));
        prog.push_back(encodeReg(opSt, 5, 9, 0));
        prog.push_back(encodeReg(opLd, 6, 9, 0));
        prog.push_back(encodeReg(opXor, 7, 6, 4));
        prog.push_back(encodeReg(opSt, 7, 9, 0));
        prog.push_back(encodeReg(opHalt, 0, 0, 0));
        runTest("storeOrder");

        prog.delete();
        prog.push_back(encodeImm(opLdi, 9, 8'h80));
        prog.push_back(encodeReg(opLd, 1, 9, 7));
        prog.push_back(encodeReg(opSt, 1, 9, 8));
        prog.push_back(encodeReg(opHalt, 0, 0, 0));
        runTest("haltTiming");

        $display("Summary: %0d tests run, %0d failing, %0d errors in all",
                 testsRun, testsFailed, errorCount);
        if (errorCount == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire
